//--- src/argmax_classifier.sv
`timescale 1ns/1ns
`default_nettype none

module argmax_classifier (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       frame_start,
  input  logic                       score_we,
  input  classifier_pkg::score_t     score_in,
  output logic                       valid,
  output classifier_pkg::class_idx_t class_out
);

  // --------------------
  // loader to tree
  // --------------------

  // frame contents, stable while run is high
  classifier_pkg::score_bank_t bank;
  logic                        run;

  // collects one frame of scores
  score_loader u_loader (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .score_we    (score_we),
    .score_in    (score_in),
    .bank        (bank),
    .run         (run)
  );

  // pipelined argmax over the full bank
  compare_tree u_tree (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .bank      (bank),
    .valid     (valid),
    .class_out (class_out)
  );

endmodule

`default_nettype wire

//--- src/classifier_pkg.sv
`default_nettype none

`include "classifier_settings.svh"

package classifier_pkg;

  // --------------------
  // scalar fields
  // --------------------

  // raw class score, larger is better
  typedef logic [`SCORE_LEN-1:0] score_t;

  // class number, equal to the bank slot it was written to
  typedef logic [`IDX_LEN-1:0] class_idx_t;

  // --------------------
  // composite types
  // --------------------

  // one contender in the tree
  // index on top so a dump reads as idx:score
  typedef struct packed {
    class_idx_t idx;
    score_t     score;
  } cand_t;

  // whole frame of scores, slot 0 in the low bits
  typedef score_t [`CLS_COUNT-1:0] score_bank_t;

endpackage

`default_nettype wire

//--- src/classifier_settings.svh
`ifndef CLASSIFIER_SETTINGS_SVH
`define CLASSIFIER_SETTINGS_SVH

// --------------------
// frame size
// --------------------

// number of output classes, one score each
`define CLS_COUNT 200

// --------------------
// field widths
// --------------------

// unsigned score from the upstream layer
`define SCORE_LEN 16

// class index, must cover CLS_COUNT - 1
`define IDX_LEN 8

// --------------------
// comparator tree
// --------------------

// pipeline levels, ceil(log2(CLS_COUNT))
`define TREE_DEPTH 8

`endif

//--- src/compare_2.sv
`timescale 1ns/1ns
`default_nettype none

module compare_2 (
  input  logic                  clk,
  input  logic                  rst_n,
  input  classifier_pkg::cand_t a,
  input  classifier_pkg::cand_t b,
  output classifier_pkg::cand_t q
);

  // --------------------
  // selection
  // --------------------

  logic a_wins;

  // a always carries the lower index, so >= settles ties
  // in favour of the lower class
  assign a_wins = (a.score >= b.score);

  // --------------------
  // output register
  // --------------------

  // updates every cycle, no enable
  // several frames' worth of partial results may be in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (a_wins) begin
      q <= a;
    end else begin
      q <= b;
    end
  end

endmodule

`default_nettype wire

//--- src/compare_tree.sv
`timescale 1ns/1ns
`default_nettype none

`include "classifier_settings.svh"

module compare_tree (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        run,
  input  classifier_pkg::score_bank_t bank,
  output logic                        valid,
  output classifier_pkg::class_idx_t  class_out
);

  localparam int NUM_LEVELS = `TREE_DEPTH;
  localparam int CNT_W      = $clog2(`TREE_DEPTH + 1);

  // number of candidates entering a given level
  function automatic int width_at(input int level);
    int n;
    int k;
    n = `CLS_COUNT;
    for (k = 0; k < level; k++) begin
      n = (n + 1) / 2;
    end
    return n;
  endfunction

  // --------------------
  // elaboration checks
  // --------------------

  if (width_at(NUM_LEVELS) != 1) begin : g_depth_check
    $error("compare_tree: TREE_DEPTH too small for CLS_COUNT");
  end

  if (`CLS_COUNT > (1 << `IDX_LEN)) begin : g_idx_check
    $error("compare_tree: IDX_LEN too narrow for CLS_COUNT");
  end

  // --------------------
  // candidate storage
  // --------------------

  // row 0 is the bank, row NUM_LEVELS holds the winner in slot 0
  // rows shrink level by level, slots past the live width are tied off
  classifier_pkg::cand_t lvl [0:NUM_LEVELS][0:`CLS_COUNT-1];

  logic [CNT_W-1:0] run_cnt;

  // tag each score with its slot number
  for (genvar i = 0; i < `CLS_COUNT; i++) begin : g_leaf
    assign lvl[0][i] = '{idx: classifier_pkg::class_idx_t'(i), score: bank[i]};
  end

  // --------------------
  // tree levels
  // --------------------

  for (genvar lv = 0; lv < NUM_LEVELS; lv++) begin : g_level
    localparam int N_IN   = width_at(lv);
    localparam int N_PAIR = N_IN / 2;
    localparam int N_OUT  = width_at(lv + 1);

    // neighbours in ascending order, lower index on port a
    for (genvar p = 0; p < N_PAIR; p++) begin : g_pair
      compare_2 u_cmp (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (lvl[lv][2*p]),
        .b     (lvl[lv][2*p+1]),
        .q     (lvl[lv+1][p])
      );
    end

    // odd leftover, one register so it lines up with the pairs
    // it lands in the last slot and stays highest in index order
    if (N_IN % 2 == 1) begin : g_odd
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          lvl[lv+1][N_PAIR] <= '0;
        end else begin
          lvl[lv+1][N_PAIR] <= lvl[lv][N_IN-1];
        end
      end
    end

    // slots beyond this level's width
    for (genvar u = N_OUT; u < `CLS_COUNT; u++) begin : g_unused
      assign lvl[lv+1][u] = '0;
    end
  end

  // --------------------
  // valid timing
  // --------------------

  // counts cycles of run, stops at the tree depth
  // by then the last level holds the result of the stable bank
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_cnt <= '0;
    end else if (!run) begin
      run_cnt <= '0;
    end else if (run_cnt != CNT_W'(NUM_LEVELS)) begin
      run_cnt <= run_cnt + 1'b1;
    end
  end

  // run in the term so valid drops together with run on frame_start
  assign valid     = run && (run_cnt == CNT_W'(NUM_LEVELS));
  assign class_out = lvl[NUM_LEVELS][0].idx;

endmodule

`default_nettype wire

//--- src/score_loader.sv
`timescale 1ns/1ns
`default_nettype none

`include "classifier_settings.svh"

module score_loader (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        frame_start,
  input  logic                        score_we,
  input  classifier_pkg::score_t      score_in,
  output classifier_pkg::score_bank_t bank,
  output logic                        run
);

  // pointer reaches CLS_COUNT when the bank is full
  localparam int PTR_W = $clog2(`CLS_COUNT + 1);

  logic [PTR_W-1:0] wr_ptr;
  logic             bank_full;
  logic             wr_en;

  // --------------------
  // write control
  // --------------------

  assign bank_full = (wr_ptr == PTR_W'(`CLS_COUNT));

  // frame_start takes priority, a write in the same cycle is dropped
  // writes past the last slot are ignored
  assign wr_en = score_we && !frame_start && !bank_full;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      run    <= 1'b0;
    end else if (frame_start) begin
      wr_ptr <= '0;
      run    <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // one cycle behind the pointer reaching full
      run <= bank_full;
    end
  end

  // --------------------
  // score bank
  // --------------------

  // slot number is the class index
  // contents are don't-care until the frame is complete
  always_ff @(posedge clk) begin
    if (wr_en) begin
      bank[wr_ptr] <= score_in;
    end
  end

endmodule

`default_nettype wire

//--- testbench/argmax_classifier_props.sv
`timescale 1ns/1ns
`default_nettype none

`include "classifier_settings.svh"

module argmax_classifier_props (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       frame_start,
  input logic                       valid,
  input classifier_pkg::class_idx_t class_out
);

  // read by the testbench at the end of the run
  int fail_count = 0;

  // --------------------
  // protocol
  // --------------------

  a_reset_low: assert property (@(posedge clk) !rst_n |-> !valid)
    else begin
      fail_count++;
      $error("valid high during reset");
    end

  a_restart_drop: assert property (@(posedge clk) disable iff (!rst_n)
    frame_start |=> !valid)
    else begin
      fail_count++;
      $error("valid still high after frame_start");
    end

  a_class_range: assert property (@(posedge clk) disable iff (!rst_n)
    valid |-> (class_out < `CLS_COUNT))
    else begin
      fail_count++;
      $error("class_out out of range");
    end

  // result is held until the next frame
  a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    valid && !frame_start |=> valid)
    else begin
      fail_count++;
      $error("valid dropped without frame_start");
    end

endmodule

bind argmax_classifier argmax_classifier_props props_inst (
  .clk         (clk),
  .rst_n       (rst_n),
  .frame_start (frame_start),
  .valid       (valid),
  .class_out   (class_out)
);

`default_nettype wire

//--- testbench/argmax_classifier_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "classifier_settings.svh"

module argmax_classifier_tb;

  localparam int MAX_GAP      = 3;
  localparam int N_RANDOM     = 6;
  localparam int EXTRA_WRITES = 5;
  localparam int PARTIAL_LEN  = 77;
  // frames run below plus a couple spare
  localparam int FRAME_BUDGET = 15;
  localparam int CYCLE_LIMIT  =
    FRAME_BUDGET * (`CLS_COUNT * (MAX_GAP + 1) + `TREE_DEPTH + 20) + 16;

  localparam int MODE_RANDOM    = 0;
  localparam int MODE_TIE       = 1;
  localparam int MODE_TIE_LAST  = 2;
  localparam int MODE_MAX_FIRST = 3;
  localparam int MODE_MAX_LAST  = 4;
  localparam int MODE_FLAT      = 5;

  localparam classifier_pkg::score_t TOP_SCORE = {`SCORE_LEN{1'b1}};

  logic                       clk;
  logic                       rst_n;
  logic                       frame_start;
  logic                       score_we;
  classifier_pkg::score_t     score_in;
  logic                       valid;
  classifier_pkg::class_idx_t class_out;

  classifier_pkg::score_t     frame_scores [`CLS_COUNT];
  classifier_pkg::class_idx_t last_class;
  logic [31:0]                rng_state = 32'd83757;
  int                         cycle_count = 0;

  argmax_classifier argmax_classifier_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .score_we    (score_we),
    .score_in    (score_in),
    .valid       (valid),
    .class_out   (class_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic fail_run(input string reason);
    $display("TB FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_class(input classifier_pkg::class_idx_t got,
                             input classifier_pkg::class_idx_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
      fail_run("wrong class index");
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
      fail_run("wrong valid level");
    end
  endtask

  // lowest index wins on equal scores
  function automatic int model_argmax();
    int best;
    int k;
    best = 0;
    for (k = 1; k < `CLS_COUNT; k++) begin
      if (frame_scores[k] > frame_scores[best]) begin
        best = k;
      end
    end
    return best;
  endfunction

  // --------------------
  // stimulus
  // --------------------

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      score_we    <= 1'b0;
      frame_start <= 1'b0;
    end
  endtask

  task automatic write_score(input classifier_pkg::score_t s);
    @(posedge clk);
    frame_start <= 1'b0;
    score_we    <= 1'b1;
    score_in    <= s;
  endtask

  // with_write puts a strobe in the same cycle, which must be lost
  task automatic start_frame(input logic with_write);
    @(posedge clk);
    frame_start <= 1'b1;
    score_we    <= with_write;
    score_in    <= TOP_SCORE;
    @(posedge clk);
    frame_start <= 1'b0;
    score_we    <= 1'b0;
    @(negedge clk);
    check_level(valid, 1'b0, "valid after frame_start");
  endtask

  task automatic fill_frame(input int mode);
    classifier_pkg::score_t flat;
    int i;
    int j;
    int k;
    flat = classifier_pkg::score_t'(next_rand());
    for (k = 0; k < `CLS_COUNT; k++) begin
      if (mode == MODE_RANDOM) begin
        frame_scores[k] = classifier_pkg::score_t'(next_rand());
      end else if (mode == MODE_FLAT) begin
        frame_scores[k] = flat;
      end else begin
        // keep below the forced maximum
        frame_scores[k] = classifier_pkg::score_t'(next_rand()) >> 1;
      end
    end
    i = next_rand() % `CLS_COUNT;
    j = next_rand() % `CLS_COUNT;
    if (j == i) begin
      j = (i + 1) % `CLS_COUNT;
    end
    case (mode)
      MODE_TIE: begin
        frame_scores[i] = TOP_SCORE;
        frame_scores[j] = TOP_SCORE;
      end
      MODE_TIE_LAST: begin
        // last slot rides the odd leftover path
        frame_scores[`CLS_COUNT-1]              = TOP_SCORE;
        frame_scores[next_rand() % (`CLS_COUNT-1)] = TOP_SCORE;
      end
      MODE_MAX_FIRST: frame_scores[0] = TOP_SCORE;
      MODE_MAX_LAST:  frame_scores[`CLS_COUNT-1] = TOP_SCORE;
      default: ;
    endcase
  endtask

  task automatic run_frame(input int mode, input logic restart_write);
    classifier_pkg::class_idx_t exp_class;
    int k;
    start_frame(restart_write);
    fill_frame(mode);
    exp_class = classifier_pkg::class_idx_t'(model_argmax());
    for (k = 0; k < `CLS_COUNT; k++) begin
      idle(next_rand() % (MAX_GAP + 1));
      write_score(frame_scores[k]);
    end
    // edge that captures the last score
    @(posedge clk);
    score_we <= 1'b0;
    @(negedge clk);
    check_level(valid, 1'b0, "valid at last write");
    repeat (`TREE_DEPTH) begin
      @(negedge clk);
      check_level(valid, 1'b0, "valid inside tree latency");
    end
    repeat (4) begin
      @(negedge clk);
      check_level(valid, 1'b1, "valid after tree latency");
      check_class(class_out, exp_class, "class_out");
    end
    last_class = exp_class;
  endtask

  // bank is full, none of these may land
  task automatic extra_writes();
    repeat (EXTRA_WRITES) begin
      write_score(TOP_SCORE);
    end
    @(posedge clk);
    score_we <= 1'b0;
    repeat (`TREE_DEPTH + 2) begin
      @(negedge clk);
      check_level(valid, 1'b1, "valid after extra writes");
      check_class(class_out, last_class, "class_out after extra writes");
    end
  endtask

  task automatic partial_frame(input int n);
    start_frame(1'b0);
    repeat (n) begin
      idle(next_rand() % (MAX_GAP + 1));
      write_score(classifier_pkg::score_t'(next_rand()));
    end
    @(posedge clk);
    score_we <= 1'b0;
    @(negedge clk);
    check_level(valid, 1'b0, "valid during partial frame");
  endtask

  // --------------------
  // timeout
  // --------------------

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      fail_run("timeout");
    end
  end

  // bound checker failures, picked up once the edge has settled
  always @(negedge clk) begin
    if (argmax_classifier_inst.props_inst.fail_count != 0) begin
      $display("A protocol assertion failed at %0t ns", $time);
      fail_run("protocol assertions failed");
    end
  end

  // --------------------
  // test sequence
  // --------------------

  initial begin
    rst_n       = 1'b0;
    frame_start = 1'b0;
    score_we    = 1'b0;
    score_in    = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    run_frame(MODE_RANDOM, 1'b0);
    extra_writes();
    repeat (N_RANDOM - 1) run_frame(MODE_RANDOM, 1'b0);
    run_frame(MODE_TIE, 1'b0);
    run_frame(MODE_TIE_LAST, 1'b0);
    run_frame(MODE_MAX_FIRST, 1'b0);
    run_frame(MODE_MAX_LAST, 1'b0);
    run_frame(MODE_FLAT, 1'b0);
    // restart mid frame, then a frame whose first strobe collides
    partial_frame(PARTIAL_LEN);
    run_frame(MODE_RANDOM, 1'b1);
    idle(4);
    @(negedge clk);

    if (argmax_classifier_inst.props_inst.fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("Assertion failures: %0d", argmax_classifier_inst.props_inst.fail_count);
      $display("TB FAILED");
      $fatal(1, "protocol assertions failed");
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/classifier_pkg.sv
src/compare_2.sv
src/compare_tree.sv
src/score_loader.sv
src/argmax_classifier.sv
testbench/argmax_classifier_props.sv
testbench/argmax_classifier_tb.sv
